/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
design/isa_pkg.sv
design/core_pkg.sv
design/idu_decode.sv
design/regfile.sv
design/exu_alu.sv
design/exu_pc.sv
design/lsu.sv
design/cpu_top.sv
tb/cpu_assertions.sv
tb/cpu_tb.sv

/* design/core_pkg.sv */
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_strb_t;

    // decoder output, shared by every unit.
    typedef struct packed {
        isa_pkg::inst_kind_e kind;
        isa_pkg::inst_fmt_e  fmt;
        reg_idx_t            rs1;
        reg_idx_t            rs2;
        reg_idx_t            rd;
        word_t               imm;
        logic                reg_we;
    } decoded_t;

    // data memory request, word aligned.
    typedef struct packed {
        word_t      addr;
        word_t      wdata;
        byte_strb_t strb;
        logic       re;
    } dmem_req_t;

endpackage

/* design/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
    parameter core_pkg::word_t RESET_PC = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    output core_pkg::word_t     imem_addr,
    input  core_pkg::word_t     imem_rdata,
    output core_pkg::dmem_req_t dmem_req,
    input  core_pkg::word_t     dmem_rdata,
    output logic                halt
);

    core_pkg::decoded_t  dec;
    core_pkg::word_t     src1;
    core_pkg::word_t     src2;
    core_pkg::word_t     alu_result;
    core_pkg::word_t     pc;
    core_pkg::word_t     pc_target;
    core_pkg::word_t     load_data;
    core_pkg::word_t     wb_data;
    core_pkg::dmem_req_t lsu_req;
    logic                pc_w_en;

    idu_decode idu_decode_inst (
        .instr(imem_rdata),
        .dec  (dec)
    );

    regfile regfile_inst (
        .clk  (clk),
        .rst_n(rst_n),
        .we   (dec.reg_we),
        .rd   (dec.rd),
        .wdata(wb_data),
        .rs1  (dec.rs1),
        .rs2  (dec.rs2),
        .src1 (src1),
        .src2 (src2)
    );

    exu_alu exu_alu_inst (
        .dec       (dec),
        .src1      (src1),
        .src2      (src2),
        .alu_result(alu_result)
    );

    exu_pc #(
        .RESET_PC(RESET_PC)
    ) exu_pc_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec       (dec),
        .src1      (src1),
        .alu_result(alu_result),
        .pc        (pc),
        .pc_target (pc_target),
        .pc_w_en   (pc_w_en)
    );

    lsu lsu_inst (
        .dec       (dec),
        .src2      (src2),
        .alu_result(alu_result),
        .dmem_rdata(dmem_rdata),
        .dmem_req  (lsu_req),
        .load_data (load_data)
    );

    // no memory traffic while in reset.
    assign dmem_req.addr  = lsu_req.addr;
    assign dmem_req.wdata = lsu_req.wdata;
    assign dmem_req.strb  = rst_n ? lsu_req.strb : '0;
    assign dmem_req.re    = rst_n & lsu_req.re;

    // **************************************************
    // write-back select.
    // **************************************************
    always_comb begin
        case (dec.kind)
            isa_pkg::kind_lw,
            isa_pkg::kind_lbu:  wb_data = load_data;
            isa_pkg::kind_jal,
            isa_pkg::kind_jalr: wb_data = pc + 32'd4;   // link.
            isa_pkg::kind_auipc: wb_data = pc_target;
            default:            wb_data = alu_result;
        endcase
    end

    assign imem_addr = pc;
    assign halt      = ~pc_w_en;

endmodule

/* design/exu_alu.sv */
`timescale 1ns/1ps

module exu_alu (
    input  core_pkg::decoded_t dec,
    input  core_pkg::word_t    src1,
    input  core_pkg::word_t    src2,
    output core_pkg::word_t    alu_result
);

    core_pkg::word_t op_b;

    // immediate operand for I and S formats.
    assign op_b = ((dec.fmt == isa_pkg::fmt_i) || (dec.fmt == isa_pkg::fmt_s)) ?
                  dec.imm : src2;

    always_comb begin
        case (dec.kind)
            isa_pkg::kind_addi,
            isa_pkg::kind_add,
            isa_pkg::kind_lw,
            isa_pkg::kind_lbu,
            isa_pkg::kind_sh,
            isa_pkg::kind_sw: begin
                alu_result = src1 + op_b;   // also the memory address.
            end
            isa_pkg::kind_sub: begin
                alu_result = src1 - op_b;
            end
            isa_pkg::kind_sltiu,
            isa_pkg::kind_sltu: begin
                alu_result = {31'b0, src1 < op_b};
            end
            isa_pkg::kind_andi: alu_result = src1 & op_b;
            isa_pkg::kind_or:   alu_result = src1 | op_b;
            isa_pkg::kind_xor:  alu_result = src1 ^ op_b;
            isa_pkg::kind_srai: begin
                alu_result = core_pkg::word_t'($signed(src1) >>> op_b[4:0]);
            end
            // branch condition in bit 0.
            isa_pkg::kind_beq: alu_result = {31'b0, src1 == op_b};
            isa_pkg::kind_bne: alu_result = {31'b0, src1 != op_b};
            default:           alu_result = '0;
        endcase
    end

endmodule

/* design/exu_pc.sv */
`timescale 1ns/1ps

module exu_pc #(
    parameter core_pkg::word_t RESET_PC = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::decoded_t dec,
    input  core_pkg::word_t    src1,
    input  core_pkg::word_t    alu_result,
    output core_pkg::word_t    pc,
    output core_pkg::word_t    pc_target,
    output logic               pc_w_en
);

    core_pkg::word_t adder_a;
    core_pkg::word_t adder_b;
    core_pkg::word_t adder_sum;
    core_pkg::word_t next_pc;
    logic            is_jalr;

    assign is_jalr = (dec.kind == isa_pkg::kind_jalr);
    assign adder_a = is_jalr ? src1 : pc;

    always_comb begin
        case (dec.kind)
            isa_pkg::kind_jal,
            isa_pkg::kind_jalr: adder_b = dec.imm;
            isa_pkg::kind_beq,
            isa_pkg::kind_bne:  adder_b = alu_result[0] ? dec.imm : 32'd4;
            default:            adder_b = 32'd4;   // auipc too, its sum is pc_target.
        endcase
    end

    assign adder_sum = adder_a + adder_b;
    assign next_pc   = {adder_sum[31:1], adder_sum[0] & ~is_jalr};
    assign pc_target = pc + dec.imm;

    // halting formats freeze the pc.
    always_comb begin
        case (dec.fmt)
            isa_pkg::fmt_r, isa_pkg::fmt_i, isa_pkg::fmt_s,
            isa_pkg::fmt_b, isa_pkg::fmt_u, isa_pkg::fmt_j: pc_w_en = 1'b1;
            default:                                        pc_w_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (pc_w_en) begin
            pc <= next_pc;
        end
    end

endmodule

/* design/idu_decode.sv */
`timescale 1ns/1ps

module idu_decode (
    input  core_pkg::word_t    instr,
    output core_pkg::decoded_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    core_pkg::word_t imm_i;
    core_pkg::word_t imm_s;
    core_pkg::word_t imm_b;
    core_pkg::word_t imm_u;
    core_pkg::word_t imm_j;
    isa_pkg::inst_kind_e kind;
    isa_pkg::inst_fmt_e  fmt;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // **************************************************
    // immediates, all sign-extended from bit 31.
    // **************************************************
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // **************************************************
    // kind and format match.
    // **************************************************
    always_comb begin
        kind = isa_pkg::kind_illegal;
        fmt  = isa_pkg::fmt_n;
        case (opcode)
            isa_pkg::op_auipc: begin
                kind = isa_pkg::kind_auipc;
                fmt  = isa_pkg::fmt_u;
            end
            isa_pkg::op_jal: begin
                kind = isa_pkg::kind_jal;
                fmt  = isa_pkg::fmt_j;
            end
            isa_pkg::op_jalr: begin
                if (funct3 == isa_pkg::f3_jalr) begin
                    kind = isa_pkg::kind_jalr;
                    fmt  = isa_pkg::fmt_i;
                end
            end
            isa_pkg::op_branch: begin
                fmt = isa_pkg::fmt_b;
                case (funct3)
                    isa_pkg::f3_beq: kind = isa_pkg::kind_beq;
                    isa_pkg::f3_bne: kind = isa_pkg::kind_bne;
                    default:         fmt = isa_pkg::fmt_n;
                endcase
            end
            isa_pkg::op_load: begin
                fmt = isa_pkg::fmt_i;
                case (funct3)
                    isa_pkg::f3_lw:  kind = isa_pkg::kind_lw;
                    isa_pkg::f3_lbu: kind = isa_pkg::kind_lbu;
                    default:         fmt = isa_pkg::fmt_n;
                endcase
            end
            isa_pkg::op_store: begin
                fmt = isa_pkg::fmt_s;
                case (funct3)
                    isa_pkg::f3_sh: kind = isa_pkg::kind_sh;
                    isa_pkg::f3_sw: kind = isa_pkg::kind_sw;
                    default:        fmt = isa_pkg::fmt_n;
                endcase
            end
            isa_pkg::op_imm: begin
                fmt = isa_pkg::fmt_i;
                case (funct3)
                    isa_pkg::f3_addi:  kind = isa_pkg::kind_addi;
                    isa_pkg::f3_sltiu: kind = isa_pkg::kind_sltiu;
                    isa_pkg::f3_andi:  kind = isa_pkg::kind_andi;
                    isa_pkg::f3_srai: begin
                        if (funct7 == isa_pkg::f7_alt) kind = isa_pkg::kind_srai;
                        else fmt = isa_pkg::fmt_n;
                    end
                    default: fmt = isa_pkg::fmt_n;
                endcase
            end
            isa_pkg::op_reg: begin
                fmt = isa_pkg::fmt_r;
                case ({funct7, funct3})
                    {isa_pkg::f7_base, isa_pkg::f3_add_sub}: kind = isa_pkg::kind_add;
                    {isa_pkg::f7_alt, isa_pkg::f3_add_sub}:  kind = isa_pkg::kind_sub;
                    {isa_pkg::f7_base, isa_pkg::f3_sltu}:    kind = isa_pkg::kind_sltu;
                    {isa_pkg::f7_base, isa_pkg::f3_xor}:     kind = isa_pkg::kind_xor;
                    {isa_pkg::f7_base, isa_pkg::f3_or}:      kind = isa_pkg::kind_or;
                    default:                                 fmt = isa_pkg::fmt_n;
                endcase
            end
            isa_pkg::op_system: begin
                if (instr == isa_pkg::ebreak_word) kind = isa_pkg::kind_ebreak;
            end
            default: ;
        endcase
    end

    assign dec.kind = kind;
    assign dec.fmt  = fmt;
    assign dec.rs1  = instr[19:15];
    assign dec.rs2  = instr[24:20];
    assign dec.rd   = instr[11:7];

    always_comb begin
        case (fmt)
            isa_pkg::fmt_i: dec.imm = imm_i;
            isa_pkg::fmt_s: dec.imm = imm_s;
            isa_pkg::fmt_b: dec.imm = imm_b;
            isa_pkg::fmt_u: dec.imm = imm_u;
            isa_pkg::fmt_j: dec.imm = imm_j;
            default:        dec.imm = '0;
        endcase
    end

    // no write-back for stores, branches and halting words.
    assign dec.reg_we = (fmt != isa_pkg::fmt_s) && (fmt != isa_pkg::fmt_b) &&
                        (fmt != isa_pkg::fmt_n);

endmodule

/* design/isa_pkg.sv */
package isa_pkg;

    // **************************************************
    // decoded instruction kind and format.
    // **************************************************
    typedef enum logic [4:0] {
        kind_auipc,
        kind_jal,
        kind_jalr,
        kind_beq,
        kind_bne,
        kind_lw,
        kind_lbu,
        kind_sh,
        kind_sw,
        kind_addi,
        kind_sltiu,
        kind_andi,
        kind_srai,
        kind_add,
        kind_sub,
        kind_sltu,
        kind_xor,
        kind_or,
        kind_ebreak,
        kind_illegal
    } inst_kind_e;

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_n   // ebreak and anything unknown.
    } inst_fmt_e;

    // **************************************************
    // encoding constants.
    // **************************************************
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [2:0] f3_jalr    = 3'b000;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [2:0] f3_lw      = 3'b010;
    localparam logic [2:0] f3_lbu     = 3'b100;
    localparam logic [2:0] f3_sh      = 3'b001;
    localparam logic [2:0] f3_sw      = 3'b010;
    localparam logic [2:0] f3_addi    = 3'b000;
    localparam logic [2:0] f3_sltiu   = 3'b011;
    localparam logic [2:0] f3_andi    = 3'b111;
    localparam logic [2:0] f3_srai    = 3'b101;
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;   // sub, srai.

    localparam logic [31:0] ebreak_word = 32'h0010_0073;

endpackage

/* design/lsu.sv */
`timescale 1ns/1ps

module lsu (
    input  core_pkg::decoded_t  dec,
    input  core_pkg::word_t     src2,
    input  core_pkg::word_t     alu_result,
    input  core_pkg::word_t     dmem_rdata,
    output core_pkg::dmem_req_t dmem_req,
    output core_pkg::word_t     load_data
);

    logic [7:0] load_byte;

    assign dmem_req.addr = {alu_result[31:2], 2'b00};
    assign dmem_req.re   = (dec.kind == isa_pkg::kind_lw) || (dec.kind == isa_pkg::kind_lbu);

    always_comb begin
        dmem_req.strb  = '0;
        dmem_req.wdata = src2;
        case (dec.kind)
            isa_pkg::kind_sw: dmem_req.strb = 4'b1111;
            isa_pkg::kind_sh: begin
                dmem_req.strb  = alu_result[1] ? 4'b1100 : 4'b0011;
                dmem_req.wdata = {2{src2[15:0]}};   // both halves.
            end
            default: ;
        endcase
    end

    // byte lane from the low address bits.
    assign load_byte = dmem_rdata[alu_result[1:0]*8 +: 8];
    assign load_data = (dec.kind == isa_pkg::kind_lbu) ? {24'b0, load_byte} : dmem_rdata;

endmodule

/* design/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               we,
    input  core_pkg::reg_idx_t rd,
    input  core_pkg::word_t    wdata,
    input  core_pkg::reg_idx_t rs1,
    input  core_pkg::reg_idx_t rs2,
    output core_pkg::word_t    src1,
    output core_pkg::word_t    src2
);

    core_pkg::word_t regs [1:31];   // x0 has no storage.

    always_ff @(posedge clk) begin
        if (rst_n && we && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    // combinational reads.
    assign src1 = (rs1 == '0) ? '0 : regs[rs1];
    assign src2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* tb/cpu_assertions.sv */
`timescale 1ns/1ps

module cpu_assertions (
    input logic                clk,
    input logic                rst_n,
    input core_pkg::word_t     imem_addr,
    input core_pkg::dmem_req_t dmem_req,
    input logic                halt
);

    // fetch is always word aligned.
    pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) imem_addr[1:0] == 2'b00
    ) else $error("imem_addr not word aligned: 0x%08h", imem_addr);

    no_store_in_reset: assert property (
        @(posedge clk) !rst_n |-> dmem_req.strb == '0
    ) else $error("store strobe active during reset");

    // a halted core holds its pc.
    halt_holds_pc: assert property (
        @(posedge clk) disable iff (!rst_n) halt |=> $stable(imem_addr)
    ) else $error("imem_addr moved while halted");

endmodule

bind cpu_top cpu_assertions cpu_assertions_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .imem_addr(imem_addr),
    .dmem_req (dmem_req),
    .halt     (halt)
);

/* tb/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

    localparam int CLK_PERIOD     = 10;
    localparam int NUM_ROWS       = 46;
    localparam int TIMEOUT_CYCLES = NUM_ROWS + 20;

    typedef struct packed {
        core_pkg::word_t      instr;
        core_pkg::word_t      pc;
        core_pkg::word_t      next_pc;
        core_pkg::byte_strb_t strb;
        logic                 re;
        core_pkg::word_t      addr;
        core_pkg::word_t      wdata;
        logic                 halt;
        logic                 run;
    } trace_row_t;

    logic                clk;
    logic                rst_n;
    core_pkg::word_t     imem_addr;
    core_pkg::word_t     imem_rdata;
    core_pkg::dmem_req_t dmem_req;
    core_pkg::word_t     dmem_rdata;
    logic                halt;

    core_pkg::word_t imem [0:63];
    core_pkg::word_t dmem [0:63];
    core_pkg::word_t preset [0:63];   // dmem contents before any store.
    integer          seed = 32'hf769;
    int              cycle_count = 0;

    // **************************************************
    // executed instructions in program order.
    // instr, pc, next pc, strb, re, store addr, store data, halt, run.
    // **************************************************
    trace_row_t rows [0:NUM_ROWS-1] = '{
        '{32'h12300093, 32'h00, 32'h04, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0}, // addi x1
        // addi x2, -5
        '{32'hFFB00113, 32'h04, 32'h08, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0},
        '{32'h002081B3, 32'h08, 32'h0C, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0},
        '{32'h40208233, 32'h0C, 32'h10, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0},
        '{32'h0020B2B3, 32'h10, 32'h14, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0},
        '{32'h00713313, 32'h14, 32'h18, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0},
        '{32'h0F017393, 32'h18, 32'h1C, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0},
        '{32'h0070E433, 32'h1C, 32'h20, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0},
        '{32'h0020C4B3, 32'h20, 32'h24, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0},
        // srai x10, x9, 4
        '{32'h4044D513, 32'h24, 32'h28, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0},
        '{32'h04302023, 32'h28, 32'h2C, 4'hF, 1'b0, 32'h40, 32'h0000011E, 1'b0, 1'b0}, // add
        '{32'h04402223, 32'h2C, 32'h30, 4'hF, 1'b0, 32'h44, 32'h00000128, 1'b0, 1'b0}, // sub
        '{32'h04502423, 32'h30, 32'h34, 4'hF, 1'b0, 32'h48, 32'h00000001, 1'b0, 1'b0}, // sltu
        '{32'h04602623, 32'h34, 32'h38, 4'hF, 1'b0, 32'h4C, 32'h00000000, 1'b0, 1'b0}, // sltiu
        '{32'h04702823, 32'h38, 32'h3C, 4'hF, 1'b0, 32'h50, 32'h000000F0, 1'b0, 1'b0}, // andi
        '{32'h04802A23, 32'h3C, 32'h40, 4'hF, 1'b0, 32'h54, 32'h000001F3, 1'b0, 1'b0}, // or
        '{32'h04902C23, 32'h40, 32'h44, 4'hF, 1'b0, 32'h58, 32'hFFFFFED8, 1'b0, 1'b0}, // xor
        '{32'h04A02E23, 32'h44, 32'h48, 4'hF, 1'b0, 32'h5C, 32'hFFFFFFED, 1'b0, 1'b0}, // srai
        '{32'h00108463, 32'h48, 32'h50, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0}, // beq taken
        '{32'h00208463, 32'h50, 32'h54, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0},
        '{32'h00109463, 32'h54, 32'h58, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0},
        '{32'h00209463, 32'h58, 32'h60, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0}, // bne taken
        '{32'h008005EF, 32'h60, 32'h68, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0}, // jal x11
        '{32'h07800693, 32'h68, 32'h6C, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0},
        '{32'h00168667, 32'h6C, 32'h78, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0}, // odd target
        '{32'h00001717, 32'h78, 32'h7C, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b0}, // auipc x14
        '{32'h08B02823, 32'h7C, 32'h80, 4'hF, 1'b0, 32'h90, 32'h00000064, 1'b0, 1'b0},
        '{32'h08C02A23, 32'h80, 32'h84, 4'hF, 1'b0, 32'h94, 32'h00000070, 1'b0, 1'b0},
        '{32'h08E02C23, 32'h84, 32'h88, 4'hF, 1'b0, 32'h98, 32'h00001078, 1'b0, 1'b0},
        '{32'h06101023, 32'h88, 32'h8C, 4'h3, 1'b0, 32'h60, 32'h01230123, 1'b0, 1'b0}, // sh low
        '{32'h06201123, 32'h8C, 32'h90, 4'hC, 1'b0, 32'h60, 32'hFFFBFFFB, 1'b0, 1'b0}, // sh high
        '{32'h08002783, 32'h90, 32'h94, 4'h0, 1'b1, 32'h00, 32'h00000000, 1'b0, 1'b0},
        '{32'h08704803, 32'h94, 32'h98, 4'h0, 1'b1, 32'h00, 32'h00000000, 1'b0, 1'b0},
        '{32'h06002883, 32'h98, 32'h9C, 4'h0, 1'b1, 32'h00, 32'h00000000, 1'b0, 1'b0},
        // from preset
        '{32'h0AF02023, 32'h9C, 32'hA0, 4'hF, 1'b0, 32'hA0, 32'h00000000, 1'b0, 1'b0},
        '{32'h0B002223, 32'hA0, 32'hA4, 4'hF, 1'b0, 32'hA4, 32'h00000000, 1'b0, 1'b0},
        '{32'h0B102423, 32'hA4, 32'hA8, 4'hF, 1'b0, 32'hA8, 32'hFFFB0123, 1'b0, 1'b0},
        '{32'h00100073, 32'hA8, 32'hA8, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b1, 1'b0}, // ebreak
        '{32'h00100073, 32'hA8, 32'hA8, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b1, 1'b0},
        '{32'h00100073, 32'hA8, 32'hA8, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b1, 1'b0},
        '{32'h00100073, 32'hA8, 32'hA8, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b1, 1'b0},
        '{32'h00002023, 32'h00, 32'h04, 4'hF, 1'b0, 32'h00, 32'h00000000, 1'b0, 1'b1}, // sw x0
        '{32'h000010B7, 32'h04, 32'h04, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b1, 1'b1}, // lui
        '{32'h000010B7, 32'h04, 32'h04, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b1, 1'b1},
        '{32'h000010B7, 32'h04, 32'h04, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b1, 1'b1},
        '{32'h000010B7, 32'h04, 32'h04, 4'h0, 1'b0, 32'h00, 32'h00000000, 1'b1, 1'b1}
    };

    cpu_top #(
        .RESET_PC(32'h0)
    ) cpu_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_rdata(imem_rdata),
        .dmem_req  (dmem_req),
        .dmem_rdata(dmem_rdata),
        .halt      (halt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // **************************************************
    // memory models.
    // **************************************************
    assign imem_rdata = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_req.addr[7:2]];

    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (dmem_req.strb[b]) begin
                dmem[dmem_req.addr[7:2]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycle_count);
            $display("=== FAIL ===");
            $fatal(1, "simulation did not finish in time");
        end
    end

    task automatic check_value(input string name, input core_pkg::word_t got,
                               input core_pkg::word_t expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic load_program(input logic run_sel);
        for (int a = 0; a < 64; a++) begin
            imem[a] = {a[5:0], 26'h0};   // opcode zero, illegal.
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].run == run_sel) begin
                imem[rows[r].pc[7:2]] = rows[r].instr;
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        #1;
    endtask

    // checks one instruction, then lets it retire.
    task automatic step_row(input trace_row_t row);
        check_value("imem_addr", imem_addr, row.pc);
        check_value("halt", {31'h0, halt}, {31'h0, row.halt});
        check_value("dmem_req.strb", {28'h0, dmem_req.strb}, {28'h0, row.strb});
        check_value("dmem_req.re", {31'h0, dmem_req.re}, {31'h0, row.re});
        if (row.strb != 4'h0) begin
            check_value("dmem_req.addr", dmem_req.addr, row.addr);
            check_value("dmem_req.wdata", dmem_req.wdata, row.wdata);
        end
        @(negedge clk);
        #1;
        check_value("next imem_addr", imem_addr, row.next_pc);
    endtask

    initial begin : stimulus
        rst_n = 1'b0;
        for (int a = 0; a < 64; a++) begin
            preset[a] = $random(seed);
            dmem[a] <= preset[a];
        end
        // lw of 0x80, lbu of byte 3 at 0x84.
        rows[34].wdata = preset[32];
        rows[35].wdata = {24'h0, preset[33][31:24]};

        for (int run_idx = 0; run_idx < 2; run_idx++) begin
            load_program(run_idx[0]);
            apply_reset();
            for (int i = 0; i < NUM_ROWS; i++) begin
                if (rows[i].run == run_idx[0]) begin
                    step_row(rows[i]);
                end
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule
